// File: branch_predictor_top.f
+incdir+rtl
rtl/bp_entry_pkg.sv
rtl/bp_packet_pkg.sv
rtl/bp_ifs.sv
rtl/branch_target_buffer.sv
rtl/fetch_pc_gen.sv
rtl/branch_resolve.sv
rtl/branch_predictor_top.sv
verif/tb_branch_predictor.sv

// File: rtl/bp_defines.svh
`ifndef bp_defines_svh
`define bp_defines_svh

// fetch address width
`define xlen 32

// branch target buffer depth, must stay a power of two
`define btb_len 16

// index sits just above the byte offset of the pc
`define pc_off_w 2
`define btb_idx_w $clog2(`btb_len)
`define btb_tag_w (`xlen - `btb_idx_w - `pc_off_w)

// first fetch address out of reset
`define reset_pc 32'h0000_1000

`endif

// File: rtl/bp_entry_pkg.sv
`include "bp_defines.svh"

package bp_entry_pkg;

    // 2-bit saturating direction counter
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_state_e;

    // one slot of the branch target buffer
    typedef struct packed {
        logic                  busy;   // slot holds a branch
        logic [`btb_tag_w-1:0] tag;    // pc bits above the index
        logic [`xlen-1:0]      target; // last known taken target
        counter_state_e        state;
    } btb_entry_t;

endpackage

// File: rtl/bp_ifs.sv
`include "bp_defines.svh"

// fetch asks and the buffer answers in the same cycle
interface btb_lookup_if;
    logic [`xlen-1:0] pc;
    logic             hit;
    logic             taken;
    logic [`xlen-1:0] target; // only meaningful with hit

    modport source (
        output pc,
        input  hit,
        input  taken,
        input  target
    );

    // answering side
    modport sink (
        input  pc,
        output hit,
        output taken,
        output target
    );
endinterface

// one training request per cycle with valid high
interface btb_train_if;
    logic             valid;
    logic [`xlen-1:0] pc;
    logic             taken;
    logic [`xlen-1:0] target;

    modport source (output valid, output pc, output taken, output target);
    modport sink   (input  valid, input  pc, input  taken, input  target);
endinterface

// File: rtl/bp_packet_pkg.sv
`include "bp_defines.svh"

package bp_packet_pkg;

    // decode reports a branch and its direct target
    typedef struct packed {
        logic             valid;
        logic [`xlen-1:0] pc;
        logic [`xlen-1:0] target;
    } alloc_req_t;

    // functional unit outcome together with the prediction the branch carried
    typedef struct packed {
        logic             valid;
        logic [`xlen-1:0] pc;
        logic             taken;       // actual direction
        logic [`xlen-1:0] target;      // actual target
        logic             pred_taken;
        logic [`xlen-1:0] pred_target;
    } resolve_req_t;

endpackage

// File: rtl/branch_predictor_top.sv
`include "bp_defines.svh"

module branch_predictor_top
    import bp_packet_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic              stall,
    input  logic              alloc_valid,
    input  logic [`xlen-1:0]  alloc_pc,
    input  logic [`xlen-1:0]  alloc_target,
    input  logic              resolve_valid,
    input  logic [`xlen-1:0]  resolve_pc,
    input  logic              resolve_taken,
    input  logic [`xlen-1:0]  resolve_target,
    input  logic              resolve_pred_taken,
    input  logic [`xlen-1:0]  resolve_pred_target,
    output logic [`xlen-1:0]  fetch_pc,
    output logic              fetch_valid,
    output logic              pred_taken,
    output logic [`xlen-1:0]  pred_target,
    output logic              mispredict,
    output logic [`xlen-1:0]  redirect_pc
);

    alloc_req_t   alloc_req;
    resolve_req_t resolve_req;

    btb_lookup_if lookup_bus ();
    btb_train_if  train_bus ();

    assign alloc_req = '{valid: alloc_valid, pc: alloc_pc, target: alloc_target};

    assign resolve_req = '{valid:       resolve_valid,
                           pc:          resolve_pc,
                           taken:       resolve_taken,
                           target:      resolve_target,
                           pred_taken:  resolve_pred_taken,
                           pred_target: resolve_pred_target};

    branch_target_buffer branch_target_buffer_inst (
        .clock  (clock),
        .reset  (reset),
        .alloc  (alloc_req),
        .lookup (lookup_bus.sink),
        .train  (train_bus.sink)
    );

    fetch_pc_gen fetch_pc_gen_inst (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .redirect    (mispredict), // redirect is never held off by stall
        .redirect_pc (redirect_pc),
        .lookup      (lookup_bus.source),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

    branch_resolve branch_resolve_inst (
        .resolve     (resolve_req),
        .train       (train_bus.source),
        .mispredict  (mispredict),
        .redirect_pc (redirect_pc)
    );

endmodule

// File: rtl/branch_resolve.sv
`include "bp_defines.svh"

module branch_resolve
    import bp_packet_pkg::*;
(
    input  resolve_req_t      resolve,
    btb_train_if.source       train,
    output logic              mispredict,
    output logic [`xlen-1:0]  redirect_pc
);

    logic dir_wrong;
    logic target_wrong;

    assign dir_wrong = resolve.taken != resolve.pred_taken;

    // right direction but the buffer held a stale target
    assign target_wrong = resolve.taken && resolve.pred_taken &&
                          (resolve.target != resolve.pred_target);

    assign mispredict = resolve.valid && (dir_wrong || target_wrong);

    // fall through when not taken
    assign redirect_pc = resolve.taken ? resolve.target : resolve.pc + `xlen'd4;

    // every resolved branch trains, correct or not
    assign train.valid  = resolve.valid;
    assign train.pc     = resolve.pc;
    assign train.taken  = resolve.taken;
    assign train.target = resolve.target;

endmodule

// File: rtl/branch_target_buffer.sv
`include "bp_defines.svh"

module branch_target_buffer
    import bp_entry_pkg::*;
    import bp_packet_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  alloc_req_t alloc,
    btb_lookup_if.sink lookup,
    btb_train_if.sink  train
);

    btb_entry_t entries_q [`btb_len];
    btb_entry_t entries_d [`btb_len];

    logic [`btb_idx_w-1:0] lookup_idx;
    logic [`btb_tag_w-1:0] lookup_tag;
    btb_entry_t            lookup_entry;

    logic [`btb_idx_w-1:0] alloc_idx;
    logic [`btb_tag_w-1:0] alloc_tag;
    btb_entry_t            alloc_old;
    logic                  alloc_we;

    logic [`btb_idx_w-1:0] train_idx;
    logic [`btb_tag_w-1:0] train_tag;
    btb_entry_t            train_old;
    logic                  train_hit;
    logic                  train_we;

    function automatic logic [`btb_idx_w-1:0] idx_of(input logic [`xlen-1:0] pc);
        return pc[`btb_idx_w+`pc_off_w-1:`pc_off_w];
    endfunction

    function automatic logic [`btb_tag_w-1:0] tag_of(input logic [`xlen-1:0] pc);
        return pc[`xlen-1:`btb_idx_w+`pc_off_w];
    endfunction

    // one step toward the outcome and held at either end
    function automatic counter_state_e step_counter(input counter_state_e state,
                                                    input logic taken);
        counter_state_e next_state;
        case (state)
            strong_not_taken: next_state = taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   next_state = taken ? weak_taken     : strong_not_taken;
            weak_taken:       next_state = taken ? strong_taken   : weak_not_taken;
            strong_taken:     next_state = taken ? strong_taken   : weak_taken;
            default:          next_state = state;
        endcase
        return next_state;
    endfunction

    assign lookup_idx   = idx_of(lookup.pc);
    assign lookup_tag   = tag_of(lookup.pc);
    assign lookup_entry = entries_q[lookup_idx];

    assign lookup.hit    = lookup_entry.busy && (lookup_entry.tag == lookup_tag);
    assign lookup.taken  = lookup.hit &&
                           (lookup_entry.state inside {weak_taken, strong_taken});
    assign lookup.target = lookup_entry.target;

    // both requests are judged against the old table contents
    assign alloc_idx = idx_of(alloc.pc);
    assign alloc_tag = tag_of(alloc.pc);
    assign alloc_old = entries_q[alloc_idx];
    assign alloc_we  = alloc.valid && !(alloc_old.busy && (alloc_old.tag == alloc_tag));

    assign train_idx = idx_of(train.pc);
    assign train_tag = tag_of(train.pc);
    assign train_old = entries_q[train_idx];
    assign train_hit = train_old.busy && (train_old.tag == train_tag);
    assign train_we  = train.valid && train_hit &&
                       !(alloc_we && (alloc_idx == train_idx)); // allocation wins

    always_comb begin
        entries_d = entries_q;
        if (train_we) begin
            entries_d[train_idx].target = train.target;
            entries_d[train_idx].state  = step_counter(train_old.state, train.taken);
        end
        if (alloc_we) begin
            entries_d[alloc_idx] = '{busy:   1'b1,
                                     tag:    alloc_tag,
                                     target: alloc.target, // direct target from decode
                                     state:  strong_taken};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries_q <= '{default: '0};
        end else begin
            entries_q <= entries_d;
        end
    end

    // decode never hands over a zero target, so a hit cannot point at zero
    a_hit_target_nonzero: assert property (@(posedge clock) disable iff (reset)
        lookup.hit |-> (lookup.target != '0));

    // a taken outcome never lowers the counter and a not-taken one never raises it
    a_counter_saturates: assert property (@(posedge clock) disable iff (reset)
        train_we |-> (train.taken ? (entries_d[train_idx].state >= train_old.state)
                                  : (entries_d[train_idx].state <= train_old.state)));

    // an allocation lands whole even when training names the same slot
    a_single_writer: assert property (@(posedge clock) disable iff (reset)
        alloc_we |=> ((entries_q[$past(alloc_idx)].target == $past(alloc.target)) &&
                      (entries_q[$past(alloc_idx)].state == strong_taken)));

endmodule

// File: rtl/fetch_pc_gen.sv
`include "bp_defines.svh"

module fetch_pc_gen (
    input  logic              clock,
    input  logic              reset,
    input  logic              stall,
    input  logic              redirect,
    input  logic [`xlen-1:0]  redirect_pc,
    btb_lookup_if.source      lookup,
    output logic [`xlen-1:0]  fetch_pc,
    output logic              fetch_valid,
    output logic              pred_taken,
    output logic [`xlen-1:0]  pred_target
);

    logic [`xlen-1:0] seq_pc;
    logic [`xlen-1:0] next_pc;

    assign lookup.pc = fetch_pc; // buffer answers for the pc being fetched now
    assign seq_pc    = fetch_pc + `xlen'd4;

    // prediction for the current pc, carried down the pipe to resolve
    assign pred_taken  = lookup.hit && lookup.taken;
    assign pred_target = pred_taken ? lookup.target : seq_pc;

    // redirect beats stall, stall beats prediction
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (stall) begin
            next_pc = fetch_pc;
        end else if (pred_taken) begin
            next_pc = lookup.target;
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc    <= `reset_pc;
            fetch_valid <= 1'b0;
        end else begin
            fetch_pc    <= next_pc;
            fetch_valid <= 1'b1;
        end
    end

    // targets come from decode and the functional unit, both must be aligned
    a_pc_aligned: assert property (@(posedge clock) disable iff (reset)
        fetch_pc[`pc_off_w-1:0] == '0);

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found on PATH"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_branch_predictor \
    -f branch_predictor_top.f \
    -o tb_branch_predictor
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/tb_branch_predictor)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verif/tb_branch_predictor.sv
`include "bp_defines.svh"

module tb_branch_predictor;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [`xlen-1:0] steer_src_pc = 32'h0000_8000; // never allocated, always misses
    localparam logic [`xlen-1:0] other_pc     = 32'h0000_3000;

    logic              clock;
    logic              reset;
    logic              stall;
    logic              alloc_valid;
    logic [`xlen-1:0]  alloc_pc;
    logic [`xlen-1:0]  alloc_target;
    logic              resolve_valid;
    logic [`xlen-1:0]  resolve_pc;
    logic              resolve_taken;
    logic [`xlen-1:0]  resolve_target;
    logic              resolve_pred_taken;
    logic [`xlen-1:0]  resolve_pred_target;
    logic [`xlen-1:0]  fetch_pc;
    logic              fetch_valid;
    logic              pred_taken;
    logic [`xlen-1:0]  pred_target;
    logic              mispredict;
    logic [`xlen-1:0]  redirect_pc;

    string            current_test;
    int               error_count;
    int               test_start_errors;
    int               tests_run;
    int               tests_failed;
    bit               model_armed;
    logic [`xlen-1:0] model_next_pc;
    logic [`xlen-1:0] branch_pc;
    logic [`xlen-1:0] branch_target;

    branch_predictor_top branch_predictor_top_inst (
        .clock               (clock),
        .reset               (reset),
        .stall               (stall),
        .alloc_valid         (alloc_valid),
        .alloc_pc            (alloc_pc),
        .alloc_target        (alloc_target),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .fetch_pc            (fetch_pc),
        .fetch_valid         (fetch_valid),
        .pred_taken          (pred_taken),
        .pred_target         (pred_target),
        .mispredict          (mispredict),
        .redirect_pc         (redirect_pc)
    );

    always #10 clock = ~clock;

    task automatic report_mismatch(input string what, input logic [`xlen-1:0] expected,
                                   input logic [`xlen-1:0] actual);
        $display("CHECK FAILED test=%s check=%s expected=%h actual=%h",
                 current_test, what, expected, actual);
        error_count++;
    endtask

    task automatic check_value(input string what, input logic [`xlen-1:0] expected,
                               input logic [`xlen-1:0] actual);
        a_value: assert (actual === expected)
            else report_mismatch(what, expected, actual);
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        a_bit: assert (actual === expected)
            else report_mismatch(what, {31'd0, expected}, {31'd0, actual});
    endtask

    // fetch must come up valid one cycle after reset drops
    a_fetch_valid: assert property (@(posedge clock) disable iff (reset)
        !reset |=> fetch_valid)
        else report_mismatch("fetch_valid after reset", 32'd1, {31'd0, fetch_valid});

    a_no_spurious_mispredict: assert property (@(posedge clock) disable iff (reset)
        !resolve_valid |-> !mispredict)
        else report_mismatch("mispredict without resolve", 32'd0, {31'd0, mispredict});

    // next pc by priority: redirect, stall, predicted taken, pc plus 4
    always @(negedge clock) begin
        if (model_armed) begin
            a_next_pc: assert (fetch_pc === model_next_pc)
                else report_mismatch("next fetch pc", model_next_pc, fetch_pc);
        end
        model_armed = !reset;
        if (mispredict) begin
            model_next_pc = redirect_pc;
        end else if (stall) begin
            model_next_pc = fetch_pc;
        end else if (pred_taken) begin
            model_next_pc = pred_target;
        end else begin
            model_next_pc = fetch_pc + 32'd4;
        end
    end

    task automatic next_edge(); // inputs change 1 ns after the rising edge
        @(posedge clock);
        #1;
    endtask

    task automatic sample_point(); // outputs are stable at the falling edge
        @(negedge clock);
    endtask

    function automatic logic [`xlen-1:0] random_target();
        return 32'h0010_0000 | ($urandom & 32'h000f_fffc); // aligned, never zero
    endfunction

    task automatic begin_test(input string name);
        current_test = name;
        test_start_errors = error_count;
    endtask

    task automatic end_test();
        int new_errors;
        new_errors = error_count - test_start_errors;
        tests_run++;
        if (new_errors == 0) begin
            $display("test %s: ok", current_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d checks failed", current_test, new_errors);
        end
    endtask

    task automatic end_requests();
        next_edge();
        alloc_valid   = 1'b0;
        resolve_valid = 1'b0;
    endtask

    task automatic allocate_branch(input logic [`xlen-1:0] pc, input logic [`xlen-1:0] target);
        next_edge();
        alloc_valid  = 1'b1;
        alloc_pc     = pc;
        alloc_target = target;
        end_requests();
    endtask

    // one cycle of resolve, left high until the next drive or end_requests
    task automatic drive_resolve(input logic [`xlen-1:0] pc, input logic taken,
                                 input logic [`xlen-1:0] target, input logic p_taken,
                                 input logic [`xlen-1:0] p_target);
        next_edge();
        resolve_valid       = 1'b1;
        resolve_pc          = pc;
        resolve_taken       = taken;
        resolve_target      = target;
        resolve_pred_taken  = p_taken;
        resolve_pred_target = p_target;
    endtask

    // a not-taken prediction that turns out taken sends fetch to pc
    task automatic steer_fetch(input logic [`xlen-1:0] pc);
        drive_resolve(steer_src_pc, 1'b1, pc, 1'b0, 32'd0);
        end_requests();
        sample_point();
        check_value("steered fetch pc", pc, fetch_pc);
    endtask

    task automatic wait_for_pc(input logic [`xlen-1:0] pc, input int limit, output bit found);
        int waited;
        found = 1'b0;
        waited = 0;
        while (!found && waited < limit) begin
            sample_point();
            found = (fetch_pc == pc);
            waited++;
        end
        if (!found) begin
            $display("timeout in test %s: fetch never reached pc %h within %0d cycles",
                     current_test, pc, limit);
            error_count++;
        end
    endtask

    task automatic sequential_fetch();
        logic [`xlen-1:0] held;
        begin_test("sequential_fetch");
        sample_point();
        check_value("fetch_pc at reset", `reset_pc, fetch_pc);
        check_bit("fetch_valid in reset cycle", 1'b0, fetch_valid);
        for (int i = 1; i <= 4; i++) begin
            sample_point();
            check_value("sequential fetch_pc", `reset_pc + 4 * i, fetch_pc);
            check_bit("pred_taken on empty table", 1'b0, pred_taken);
            check_bit("fetch_valid", 1'b1, fetch_valid);
        end
        next_edge();
        stall = 1'b1;
        held = fetch_pc;
        repeat (3) begin
            sample_point();
            check_value("fetch_pc under stall", held, fetch_pc);
        end
        next_edge();
        stall = 1'b0;
        end_test();
    endtask

    task automatic allocation_hit();
        bit found;
        begin_test("allocation_hit");
        branch_pc = `reset_pc + 32'h40; // still ahead of fetch
        branch_target = random_target();
        allocate_branch(branch_pc, branch_target);
        wait_for_pc(branch_pc, 64, found);
        if (found) begin
            check_bit("pred_taken on allocated pc", 1'b1, pred_taken);
            check_value("pred_target on allocated pc", branch_target, pred_target);
            sample_point();
            check_value("fetch_pc after taken prediction", branch_target, fetch_pc);
        end
        end_test();
    endtask

    task automatic counter_training();
        begin_test("counter_training");
        // strong_taken down to weak_not_taken
        repeat (2) drive_resolve(branch_pc, 1'b0, branch_target, 1'b0, branch_target);
        end_requests();
        steer_fetch(branch_pc);
        check_bit("pred_taken after two not taken", 1'b0, pred_taken);
        sample_point();
        check_value("fetch_pc after not-taken prediction", branch_pc + 32'd4, fetch_pc);
        // third taken saturates, so one not taken still leaves weak_taken
        repeat (3) drive_resolve(branch_pc, 1'b1, branch_target, 1'b1, branch_target);
        drive_resolve(branch_pc, 1'b0, branch_target, 1'b0, branch_target);
        end_requests();
        steer_fetch(branch_pc);
        check_bit("pred_taken after retraining", 1'b1, pred_taken);
        check_value("pred_target after retraining", branch_target, pred_target);
        end_test();
    endtask

    task automatic mispredict_redirect();
        begin_test("mispredict_redirect");
        next_edge();
        stall = 1'b1;
        // predicted taken, went not taken
        drive_resolve(other_pc, 1'b0, 32'h0000_5000, 1'b1, 32'h0000_5000);
        sample_point();
        check_bit("mispredict on wrong direction", 1'b1, mispredict);
        check_value("redirect_pc on not taken", other_pc + 32'd4, redirect_pc);
        end_requests();
        sample_point();
        check_value("fetch_pc after redirect under stall", other_pc + 32'd4, fetch_pc);
        sample_point();
        check_value("fetch_pc holds under stall", other_pc + 32'd4, fetch_pc);
        // right direction, stale target
        drive_resolve(other_pc, 1'b1, 32'h0000_6000, 1'b1, 32'h0000_5000);
        sample_point();
        check_bit("mispredict on wrong target", 1'b1, mispredict);
        check_value("redirect_pc on taken", 32'h0000_6000, redirect_pc);
        end_requests();
        sample_point();
        check_value("fetch_pc after target redirect", 32'h0000_6000, fetch_pc);
        drive_resolve(other_pc, 1'b1, 32'h0000_6000, 1'b1, 32'h0000_6000);
        sample_point();
        check_bit("mispredict on correct prediction", 1'b0, mispredict);
        end_requests();
        stall = 1'b0;
        end_test();
    endtask

    task automatic aliasing_replace();
        logic [`xlen-1:0] alias_pc;
        logic [`xlen-1:0] alias_target;
        begin_test("aliasing_replace");
        alias_pc = branch_pc + 32'h0001_0000; // same index, other tag
        steer_fetch(alias_pc);
        check_bit("pred_taken on aliasing pc", 1'b0, pred_taken);
        alias_target = random_target();
        allocate_branch(alias_pc, alias_target);
        steer_fetch(alias_pc);
        check_bit("pred_taken after replacement", 1'b1, pred_taken);
        check_value("pred_target after replacement", alias_target, pred_target);
        steer_fetch(branch_pc);
        check_bit("pred_taken on evicted pc", 1'b0, pred_taken);
        end_test();
    endtask

    initial begin
        void'($urandom(6));
        clock               = 1'b0;
        reset               = 1'b1;
        stall               = 1'b0;
        alloc_valid         = 1'b0;
        alloc_pc            = '0;
        alloc_target        = '0;
        resolve_valid       = 1'b0;
        resolve_pc          = '0;
        resolve_taken       = 1'b0;
        resolve_target      = '0;
        resolve_pred_taken  = 1'b0;
        resolve_pred_target = '0;
        error_count         = 0;
        tests_run           = 0;
        tests_failed        = 0;
        model_armed         = 1'b0;
        model_next_pc       = '0;
        current_test        = "reset";
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        sequential_fetch();
        allocation_hit();
        counter_training();
        mispredict_redirect();
        aliasing_replace();
        $display("summary: %0d tests run, %0d tests failed, %0d checks failed",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
